// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opRegReg = 7'b0110011,
		opRegImm = 7'b0010011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJalr   = 7'b1100111
	} opcode_e;

	// branch compares
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	// alu functions, shared by register and immediate forms
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	typedef enum logic [2:0] {immIAlu, immIShift, immS, immB, immJ, immU} immFmt_e;

endpackage

`default_nettype wire

// File: verilog/pipeCtrlPkg.sv
`default_nettype none

package pipeCtrlPkg;

	// compare ops also produce the branch condition
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu,
		aluSge,
		aluSgeu,
		aluSne
	} aluOp_e;

	typedef enum logic [1:0] {resAlu, resMem, resPcPlus4} resultSrc_e;

	typedef enum logic [1:0] {srcReg, srcZero, srcPc} srcA_e;

	typedef enum logic [1:0] {fwdNone, fwdFromMem, fwdFromWb} fwdSel_e;

endpackage

`default_nettype wire

// File: verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
	parameter logic [rvIsaPkg::xlen-1:0] resetPc = '0
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stall,
	input  logic                      redirect,
	input  logic [rvIsaPkg::xlen-1:0] targetPc,
	input  logic [31:0]               instr,
	output logic [rvIsaPkg::xlen-1:0] pc,
	output logic [31:0]               instrD,
	output logic [rvIsaPkg::xlen-1:0] pcD,
	output logic [rvIsaPkg::xlen-1:0] pcPlus4D
);

	logic [rvIsaPkg::xlen-1:0] pcPlus4F;

	assign pcPlus4F = pc + 4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetPc;
		end else if (redirect) begin
			pc <= targetPc;
		end else if (!stall) begin
			pc <= pcPlus4F;
		end
	end

	// an all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			instrD <= '0;
		end else if (!stall) begin
			instrD <= instr;
		end
		if (!stall) begin
			pcD      <= pc;
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          flushE,
	input  logic [31:0]                   instrD,
	input  logic [rvIsaPkg::xlen-1:0]     pcD,
	input  logic [rvIsaPkg::xlen-1:0]     pcPlus4D,
	input  logic [rvIsaPkg::regAddrW-1:0] rdW,
	input  logic                          regWriteW,
	input  logic [rvIsaPkg::xlen-1:0]     resultW,
	output logic                          regWriteE,
	output pipeCtrlPkg::resultSrc_e       resultSrcE,
	output logic                          memWriteE,
	output logic                          jumpE,
	output logic                          branchE,
	output pipeCtrlPkg::aluOp_e           aluOpE,
	output pipeCtrlPkg::srcA_e            srcAE,
	output logic                          srcBImmE,
	output logic                          targetFromRegE,
	output logic [rvIsaPkg::xlen-1:0]     rd1E,
	output logic [rvIsaPkg::xlen-1:0]     rd2E,
	output logic [rvIsaPkg::xlen-1:0]     immE,
	output logic [rvIsaPkg::xlen-1:0]     pcE,
	output logic [rvIsaPkg::xlen-1:0]     pcPlus4E,
	output logic [rvIsaPkg::regAddrW-1:0] rs1E,
	output logic [rvIsaPkg::regAddrW-1:0] rs2E,
	output logic [rvIsaPkg::regAddrW-1:0] rdE
);

	rvIsaPkg::opcode_e             opD;
	logic [2:0]                    funct3D;
	logic [rvIsaPkg::regAddrW-1:0] rs1D;
	logic [rvIsaPkg::regAddrW-1:0] rs2D;
	logic                          regWriteD;
	logic                          memWriteD;
	logic                          jumpD;
	logic                          branchD;
	logic                          srcBImmD;
	logic                          targetFromRegD;
	pipeCtrlPkg::resultSrc_e       resultSrcD;
	pipeCtrlPkg::srcA_e            srcAD;
	pipeCtrlPkg::aluOp_e           aluOpD;
	rvIsaPkg::immFmt_e             immFmtD;
	logic [rvIsaPkg::xlen-1:0]     immD;
	logic [rvIsaPkg::xlen-1:0]     rd1D;
	logic [rvIsaPkg::xlen-1:0]     rd2D;
	logic [rvIsaPkg::xlen-1:0]     regs [32];

	assign opD     = rvIsaPkg::opcode_e'(instrD[6:0]);
	assign funct3D = instrD[14:12];
	assign rs1D    = instrD[19:15];
	assign rs2D    = instrD[24:20];

	// anything the main decoder does not know falls through as a bubble
	always_comb begin
		regWriteD      = 1'b0;
		memWriteD      = 1'b0;
		jumpD          = 1'b0;
		branchD        = 1'b0;
		srcBImmD       = 1'b0;
		targetFromRegD = 1'b0;
		resultSrcD     = pipeCtrlPkg::resAlu;
		srcAD          = pipeCtrlPkg::srcReg;
		immFmtD        = rvIsaPkg::immIAlu;
		case (opD)
			rvIsaPkg::opLoad: begin
				regWriteD  = 1'b1;
				srcBImmD   = 1'b1;
				resultSrcD = pipeCtrlPkg::resMem;
			end
			rvIsaPkg::opStore: begin
				memWriteD = 1'b1;
				srcBImmD  = 1'b1;
				immFmtD   = rvIsaPkg::immS;
			end
			rvIsaPkg::opRegReg: regWriteD = 1'b1;
			rvIsaPkg::opRegImm: begin
				regWriteD = 1'b1;
				srcBImmD  = 1'b1;
				if (funct3D == rvIsaPkg::f3Sll || funct3D == rvIsaPkg::f3SrlSra)
					immFmtD = rvIsaPkg::immIShift;
			end
			rvIsaPkg::opBranch: begin
				branchD = 1'b1;
				immFmtD = rvIsaPkg::immB;
			end
			rvIsaPkg::opJal: begin
				regWriteD  = 1'b1;
				jumpD      = 1'b1;
				resultSrcD = pipeCtrlPkg::resPcPlus4;
				immFmtD    = rvIsaPkg::immJ;
			end
			rvIsaPkg::opJalr: begin
				regWriteD      = 1'b1;
				jumpD          = 1'b1;
				targetFromRegD = 1'b1;
				resultSrcD     = pipeCtrlPkg::resPcPlus4;
			end
			rvIsaPkg::opLui: begin
				regWriteD = 1'b1;
				srcBImmD  = 1'b1;
				srcAD     = pipeCtrlPkg::srcZero;
				immFmtD   = rvIsaPkg::immU;
			end
			rvIsaPkg::opAuipc: begin
				regWriteD = 1'b1;
				srcBImmD  = 1'b1;
				srcAD     = pipeCtrlPkg::srcPc;
				immFmtD   = rvIsaPkg::immU;
			end
			default: ;
		endcase
	end

	// loads, stores, jumps and upper immediates all use the adder
	always_comb begin
		aluOpD = pipeCtrlPkg::aluAdd;
		if (opD == rvIsaPkg::opRegReg || opD == rvIsaPkg::opRegImm) begin
			case (funct3D)
				rvIsaPkg::f3AddSub: begin
					if (opD == rvIsaPkg::opRegReg && instrD[30])
						aluOpD = pipeCtrlPkg::aluSub;
				end
				rvIsaPkg::f3Sll:  aluOpD = pipeCtrlPkg::aluSll;
				rvIsaPkg::f3Slt:  aluOpD = pipeCtrlPkg::aluSlt;
				rvIsaPkg::f3Sltu: aluOpD = pipeCtrlPkg::aluSltu;
				rvIsaPkg::f3Xor:  aluOpD = pipeCtrlPkg::aluXor;
				rvIsaPkg::f3SrlSra: begin
					aluOpD = instrD[30] ? pipeCtrlPkg::aluSra : pipeCtrlPkg::aluSrl;
				end
				rvIsaPkg::f3Or:   aluOpD = pipeCtrlPkg::aluOr;
				default:          aluOpD = pipeCtrlPkg::aluAnd;
			endcase
		end else if (opD == rvIsaPkg::opBranch) begin
			// beq compares through the subtract result
			case (funct3D)
				rvIsaPkg::f3Beq:  aluOpD = pipeCtrlPkg::aluSub;
				rvIsaPkg::f3Bne:  aluOpD = pipeCtrlPkg::aluSne;
				rvIsaPkg::f3Blt:  aluOpD = pipeCtrlPkg::aluSlt;
				rvIsaPkg::f3Bge:  aluOpD = pipeCtrlPkg::aluSge;
				rvIsaPkg::f3Bltu: aluOpD = pipeCtrlPkg::aluSltu;
				rvIsaPkg::f3Bgeu: aluOpD = pipeCtrlPkg::aluSgeu;
				default:          aluOpD = pipeCtrlPkg::aluAdd;
			endcase
		end
	end

	always_comb begin
		case (immFmtD)
			rvIsaPkg::immIShift: immD = {27'd0, instrD[24:20]};
			rvIsaPkg::immS:      immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
			rvIsaPkg::immB: begin
				immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
			end
			rvIsaPkg::immJ: begin
				immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
			end
			rvIsaPkg::immU:      immD = {instrD[31:12], 12'd0};
			default:             immD = {{20{instrD[31]}}, instrD[31:20]};
		endcase
	end

	// x0 is cleared in reset and never written after that
	always_ff @(posedge clk) begin
		if (rst)
			regs[0] <= '0;
		else if (regWriteW && rdW != '0)
			regs[rdW] <= resultW;
	end

	// same-cycle writeback goes straight through to the read ports
	assign rd1D = (regWriteW && rdW != '0 && rdW == rs1D) ? resultW : regs[rs1D];
	assign rd2D = (regWriteW && rdW != '0 && rdW == rs2D) ? resultW : regs[rs2D];

	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			regWriteE  <= 1'b0;
			memWriteE  <= 1'b0;
			jumpE      <= 1'b0;
			branchE    <= 1'b0;
			resultSrcE <= pipeCtrlPkg::resAlu;
		end else begin
			regWriteE  <= regWriteD;
			memWriteE  <= memWriteD;
			jumpE      <= jumpD;
			branchE    <= branchD;
			resultSrcE <= resultSrcD;
		end
		aluOpE         <= aluOpD;
		srcAE          <= srcAD;
		srcBImmE       <= srcBImmD;
		targetFromRegE <= targetFromRegD;
		rd1E           <= rd1D;
		rd2E           <= rd2D;
		immE           <= immD;
		pcE            <= pcD;
		pcPlus4E       <= pcPlus4D;
		rs1E           <= rs1D;
		rs2E           <= rs2D;
		rdE            <= instrD[11:7];
	end

	x0ReadsZero: assert property (@(posedge clk) disable iff (rst)
		(rs1D == '0) |=> (rd1E == '0))
		else $error("x0 read as nonzero on port 1");

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          regWriteE,
	input  pipeCtrlPkg::resultSrc_e       resultSrcE,
	input  logic                          memWriteE,
	input  logic                          jumpE,
	input  logic                          branchE,
	input  pipeCtrlPkg::aluOp_e           aluOpE,
	input  pipeCtrlPkg::srcA_e            srcAE,
	input  logic                          srcBImmE,
	input  logic                          targetFromRegE,
	input  logic [rvIsaPkg::xlen-1:0]     rd1E,
	input  logic [rvIsaPkg::xlen-1:0]     rd2E,
	input  logic [rvIsaPkg::xlen-1:0]     immE,
	input  logic [rvIsaPkg::xlen-1:0]     pcE,
	input  logic [rvIsaPkg::xlen-1:0]     pcPlus4E,
	input  logic [rvIsaPkg::regAddrW-1:0] rdE,
	input  pipeCtrlPkg::fwdSel_e          fwdA,
	input  pipeCtrlPkg::fwdSel_e          fwdB,
	input  logic [rvIsaPkg::xlen-1:0]     resultW,
	output logic                          redirect,
	output logic [rvIsaPkg::xlen-1:0]     targetPc,
	output logic [rvIsaPkg::xlen-1:0]     aluResultM,
	output logic [rvIsaPkg::xlen-1:0]     writeData,
	output logic                          memWrite,
	output logic [rvIsaPkg::regAddrW-1:0] rdM,
	output logic                          regWriteM,
	output pipeCtrlPkg::resultSrc_e       resultSrcM,
	output logic [rvIsaPkg::xlen-1:0]     pcPlus4M
);

	localparam int shW = $clog2(rvIsaPkg::xlen);

	logic [rvIsaPkg::xlen-1:0] fwdValA;
	logic [rvIsaPkg::xlen-1:0] fwdValB;
	logic [rvIsaPkg::xlen-1:0] srcA;
	logic [rvIsaPkg::xlen-1:0] srcB;
	logic [rvIsaPkg::xlen-1:0] aluResult;
	logic [rvIsaPkg::xlen-1:0] targetSum;
	logic                      lessS;
	logic                      lessU;
	logic                      cond;

	function automatic logic [rvIsaPkg::xlen-1:0] fwdMux(
		input pipeCtrlPkg::fwdSel_e      sel,
		input logic [rvIsaPkg::xlen-1:0] regVal,
		input logic [rvIsaPkg::xlen-1:0] memVal,
		input logic [rvIsaPkg::xlen-1:0] wbVal
	);
		case (sel)
			pipeCtrlPkg::fwdFromMem: return memVal;
			pipeCtrlPkg::fwdFromWb:  return wbVal;
			default:                 return regVal;
		endcase
	endfunction

	assign fwdValA = fwdMux(fwdA, rd1E, aluResultM, resultW);
	assign fwdValB = fwdMux(fwdB, rd2E, aluResultM, resultW);

	assign srcA = (srcAE == pipeCtrlPkg::srcPc)   ? pcE :
		(srcAE == pipeCtrlPkg::srcZero) ? '0 : fwdValA;
	assign srcB = srcBImmE ? immE : fwdValB;

	assign lessS = $signed(srcA) < $signed(srcB);
	assign lessU = srcA < srcB;

	// set-style results carry the branch condition in bit 0
	always_comb begin
		aluResult = '0;
		cond      = 1'b0;
		case (aluOpE)
			pipeCtrlPkg::aluSub: begin
				aluResult = srcA - srcB;
				cond      = (srcA == srcB);
			end
			pipeCtrlPkg::aluSne: begin
				aluResult = srcA - srcB;
				cond      = (srcA != srcB);
			end
			pipeCtrlPkg::aluAnd: aluResult = srcA & srcB;
			pipeCtrlPkg::aluOr:  aluResult = srcA | srcB;
			pipeCtrlPkg::aluXor: aluResult = srcA ^ srcB;
			pipeCtrlPkg::aluSll: aluResult = srcA << srcB[shW-1:0];
			pipeCtrlPkg::aluSrl: aluResult = srcA >> srcB[shW-1:0];
			pipeCtrlPkg::aluSra: aluResult = $unsigned($signed(srcA) >>> srcB[shW-1:0]);
			pipeCtrlPkg::aluSlt: begin
				aluResult[0] = lessS;
				cond         = lessS;
			end
			pipeCtrlPkg::aluSltu: begin
				aluResult[0] = lessU;
				cond         = lessU;
			end
			pipeCtrlPkg::aluSge: begin
				aluResult[0] = !lessS;
				cond         = !lessS;
			end
			pipeCtrlPkg::aluSgeu: begin
				aluResult[0] = !lessU;
				cond         = !lessU;
			end
			default: aluResult = srcA + srcB;
		endcase
	end

	assign redirect  = jumpE || (branchE && cond);
	// jalr takes rs1 as base; bit 0 of the target is always cleared
	assign targetSum = (targetFromRegE ? fwdValA : pcE) + immE;
	assign targetPc  = {targetSum[rvIsaPkg::xlen-1:1], 1'b0};

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memWrite  <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memWrite  <= memWriteE;
		end
		aluResultM <= aluResult;
		writeData  <= fwdValB;
		rdM        <= rdE;
		resultSrcM <= resultSrcE;
		pcPlus4M   <= pcPlus4E;
	end

	aluOpKnown: assert property (@(posedge clk) disable iff (rst)
		(regWriteE || memWriteE) |-> !$isunknown(aluOpE))
		else $error("unknown alu op on a live instruction");

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  logic [31:0]                   instrD,
	input  logic [rvIsaPkg::regAddrW-1:0] rs1E,
	input  logic [rvIsaPkg::regAddrW-1:0] rs2E,
	input  logic [rvIsaPkg::regAddrW-1:0] rdE,
	input  pipeCtrlPkg::resultSrc_e       resultSrcE,
	input  logic                          redirect,
	input  logic [rvIsaPkg::regAddrW-1:0] rdM,
	input  logic                          regWriteM,
	input  logic [rvIsaPkg::regAddrW-1:0] rdW,
	input  logic                          regWriteW,
	output pipeCtrlPkg::fwdSel_e          fwdA,
	output pipeCtrlPkg::fwdSel_e          fwdB,
	output logic                          stall,
	output logic                          flushE
);

	logic [rvIsaPkg::regAddrW-1:0] rs1D;
	logic [rvIsaPkg::regAddrW-1:0] rs2D;

	// the younger result in memory wins over writeback
	function automatic pipeCtrlPkg::fwdSel_e pickFwd(input logic [rvIsaPkg::regAddrW-1:0] rs);
		if (rs != '0 && regWriteM && rdM == rs)
			return pipeCtrlPkg::fwdFromMem;
		if (rs != '0 && regWriteW && rdW == rs)
			return pipeCtrlPkg::fwdFromWb;
		return pipeCtrlPkg::fwdNone;
	endfunction

	assign rs1D = instrD[19:15];
	assign rs2D = instrD[24:20];

	always_comb begin
		fwdA = pickFwd(rs1E);
		fwdB = pickFwd(rs2E);
	end

	// load data only exists after the memory stage
	assign stall  = (resultSrcE == pipeCtrlPkg::resMem) && rdE != '0 &&
		(rdE == rs1D || rdE == rs2D);
	assign flushE = stall || redirect;

	always_comb begin
		stallRedirectExcl: assert final (!(stall && redirect))
			else $error("load-use stall together with a redirect");
	end

endmodule

`default_nettype wire

// File: verilog/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteback (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [rvIsaPkg::xlen-1:0]     aluResultM,
	input  logic [rvIsaPkg::xlen-1:0]     readData,
	input  logic [rvIsaPkg::regAddrW-1:0] rdM,
	input  logic                          regWriteM,
	input  pipeCtrlPkg::resultSrc_e       resultSrcM,
	input  logic [rvIsaPkg::xlen-1:0]     pcPlus4M,
	output logic [rvIsaPkg::regAddrW-1:0] rdW,
	output logic                          regWriteW,
	output logic [rvIsaPkg::xlen-1:0]     resultW
);

	logic [rvIsaPkg::xlen-1:0] aluResultW;
	logic [rvIsaPkg::xlen-1:0] readDataW;
	logic [rvIsaPkg::xlen-1:0] pcPlus4W;
	pipeCtrlPkg::resultSrc_e   resultSrcW;

	always_ff @(posedge clk) begin
		if (rst)
			regWriteW <= 1'b0;
		else
			regWriteW <= regWriteM;
		rdW        <= rdM;
		resultSrcW <= resultSrcM;
		aluResultW <= aluResultM;
		readDataW  <= readData;
		pcPlus4W   <= pcPlus4M;
	end

	// feeds both the register file and the forward path
	always_comb begin
		case (resultSrcW)
			pipeCtrlPkg::resMem:     resultW = readDataW;
			pipeCtrlPkg::resPcPlus4: resultW = pcPlus4W;
			default:                 resultW = aluResultW;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/riscvCore.sv
`timescale 1ns/1ps
`default_nettype none

module riscvCore #(
	parameter logic [rvIsaPkg::xlen-1:0] resetPc = '0
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [31:0]               instr,
	input  logic [rvIsaPkg::xlen-1:0] readData,
	output logic [rvIsaPkg::xlen-1:0] pc,
	output logic [rvIsaPkg::xlen-1:0] dataAddr,
	output logic [rvIsaPkg::xlen-1:0] writeData,
	output logic                      memWrite
);

	// hazard control
	logic                 stall;
	logic                 flushE;
	pipeCtrlPkg::fwdSel_e fwdA;
	pipeCtrlPkg::fwdSel_e fwdB;

	// fetch to decode, and the redirect back
	logic                      redirect;
	logic [rvIsaPkg::xlen-1:0] targetPc;
	logic [31:0]               instrD;
	logic [rvIsaPkg::xlen-1:0] pcD;
	logic [rvIsaPkg::xlen-1:0] pcPlus4D;

	// decode to execute
	logic                          regWriteE;
	pipeCtrlPkg::resultSrc_e       resultSrcE;
	logic                          memWriteE;
	logic                          jumpE;
	logic                          branchE;
	pipeCtrlPkg::aluOp_e           aluOpE;
	pipeCtrlPkg::srcA_e            srcAE;
	logic                          srcBImmE;
	logic                          targetFromRegE;
	logic [rvIsaPkg::xlen-1:0]     rd1E;
	logic [rvIsaPkg::xlen-1:0]     rd2E;
	logic [rvIsaPkg::xlen-1:0]     immE;
	logic [rvIsaPkg::xlen-1:0]     pcE;
	logic [rvIsaPkg::xlen-1:0]     pcPlus4E;
	logic [rvIsaPkg::regAddrW-1:0] rs1E;
	logic [rvIsaPkg::regAddrW-1:0] rs2E;
	logic [rvIsaPkg::regAddrW-1:0] rdE;

	// memory and writeback
	logic [rvIsaPkg::xlen-1:0]     aluResultM;
	logic [rvIsaPkg::regAddrW-1:0] rdM;
	logic                          regWriteM;
	pipeCtrlPkg::resultSrc_e       resultSrcM;
	logic [rvIsaPkg::xlen-1:0]     pcPlus4M;
	logic [rvIsaPkg::regAddrW-1:0] rdW;
	logic                          regWriteW;
	logic [rvIsaPkg::xlen-1:0]     resultW;

	assign dataAddr = aluResultM;

	fetchStage #(.resetPc(resetPc)) uFetch (.*);

	decodeStage uDecode (.*);

	executeStage uExecute (.*);

	hazardUnit uHazard (.*);

	memWriteback uMemWb (.*);

endmodule

`default_nettype wire

// File: verif/riscvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module riscvCoreTb;

	localparam logic [31:0] resetPc = 32'h0;
	localparam int resetCycles = 16;
	localparam int imemWords = 128;
	localparam int dmemWords = 64;
	// funct3 of lw and sw
	localparam logic [2:0] f3Word = 3'b010;

	logic        clk;
	logic        rst;
	logic [31:0] instr;
	logic [31:0] readData;
	logic [31:0] pc;
	logic [31:0] dataAddr;
	logic [31:0] writeData;
	logic        memWrite;

	logic [31:0] prog [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] imem [imemWords];
	logic [31:0] dmem [dmemWords];

	// word positions of instructions whose results depend on their own address
	int firstTakenPos;
	int jalPos;
	int auipcPos;
	int jalrPos;
	int auipc2Pos;
	int haltPos;

	riscvCore #(.resetPc(resetPc)) i_dut (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.readData(readData),
		.pc(pc),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.memWrite(memWrite)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] encodeR(input logic [2:0] f3, input int f7, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::opRegReg};
	endfunction

	function automatic logic [31:0] encodeI(input rvIsaPkg::opcode_e op, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] encodeS(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], rvIsaPkg::opStore};
	endfunction

	function automatic logic [31:0] encodeB(input logic [2:0] f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], rvIsaPkg::opBranch};
	endfunction

	function automatic logic [31:0] encodeJ(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rvIsaPkg::opJal};
	endfunction

	function automatic logic [31:0] encodeU(input rvIsaPkg::opcode_e op, input int rd,
		input int imm);
		return {imm[19:0], rd[4:0], op};
	endfunction

	task automatic appendInstr(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped after an error");
	endtask

	// x10 is the store base at 0x80, x20 = -3 and x21 = 5 feed the branches
	task automatic buildProgram();
		int         storeRegs [8];
		logic [2:0] brF3 [6];
		int         ntA [6];
		int         ntB [6];
		int         tkA [6];
		int         tkB [6];
		storeRegs = '{13, 3, 4, 5, 6, 7, 8, 9};
		brF3 = '{rvIsaPkg::f3Beq, rvIsaPkg::f3Bne, rvIsaPkg::f3Blt,
			rvIsaPkg::f3Bge, rvIsaPkg::f3Bltu, rvIsaPkg::f3Bgeu};
		ntA = '{20, 21, 21, 20, 20, 21};
		ntB = '{21, 21, 20, 21, 21, 20};
		tkA = '{21, 20, 20, 21, 21, 20};
		tkB = '{21, 21, 21, 20, 20, 21};
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3AddSub, 1, 0, 'h123));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3AddSub, 10, 0, 128));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3Sll, 2, 1, 'h004));
		appendInstr(encodeR(rvIsaPkg::f3AddSub, 'h00, 3, 2, 1));
		appendInstr(encodeR(rvIsaPkg::f3AddSub, 'h20, 4, 1, 3));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3SrlSra, 5, 4, 'h402));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3SrlSra, 6, 5, 'h008));
		appendInstr(encodeR(rvIsaPkg::f3Xor, 'h00, 7, 6, 5));
		appendInstr(encodeR(rvIsaPkg::f3Slt, 'h00, 8, 7, 6));
		appendInstr(encodeR(rvIsaPkg::f3Sltu, 'h00, 9, 7, 6));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3And, 11, 7, 'h7F0));
		appendInstr(encodeR(rvIsaPkg::f3Or, 'h00, 12, 11, 8));
		appendInstr(encodeR(rvIsaPkg::f3Sll, 'h00, 13, 12, 8));
		// first store takes x13 straight from the memory stage
		for (int i = 0; i < 8; i++)
			appendInstr(encodeS(storeRegs[i], 10, 4 * i));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3AddSub, 20, 0, -3));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3AddSub, 21, 0, 5));
		// per type: not taken plus marker store, then taken over two bad stores
		for (int b = 0; b < 6; b++) begin
			appendInstr(encodeB(brF3[b], ntA[b], ntB[b], 8));
			appendInstr(encodeS(21, 10, 32 + 4 * b));
			if (b == 0)
				firstTakenPos = prog.size();
			appendInstr(encodeB(brF3[b], tkA[b], tkB[b], 12));
			appendInstr(encodeS(20, 10, 124));
			appendInstr(encodeS(20, 10, 124));
		end
		appendInstr(encodeI(rvIsaPkg::opLoad, f3Word, 15, 0, 20));
		appendInstr(encodeI(rvIsaPkg::opRegImm, rvIsaPkg::f3AddSub, 16, 15, 'h55));
		appendInstr(encodeS(16, 10, 56));
		appendInstr(encodeI(rvIsaPkg::opLoad, f3Word, 17, 0, 44));
		appendInstr(encodeR(rvIsaPkg::f3AddSub, 'h20, 18, 0, 17));
		appendInstr(encodeS(18, 10, 60));
		jalPos = prog.size();
		appendInstr(encodeJ(22, 12));
		appendInstr(encodeS(20, 10, 124));
		appendInstr(encodeS(20, 10, 124));
		appendInstr(encodeS(22, 10, 64));
		auipcPos = prog.size();
		appendInstr(encodeU(rvIsaPkg::opAuipc, 23, 0));
		// lands five words past the auipc
		jalrPos = prog.size();
		appendInstr(encodeI(rvIsaPkg::opJalr, 3'b000, 24, 23, 20));
		appendInstr(encodeS(20, 10, 124));
		appendInstr(encodeS(20, 10, 124));
		appendInstr(encodeS(20, 10, 124));
		appendInstr(encodeS(24, 10, 68));
		appendInstr(encodeS(23, 10, 72));
		appendInstr(encodeU(rvIsaPkg::opLui, 25, 'hABCDE));
		appendInstr(encodeS(25, 10, 76));
		auipc2Pos = prog.size();
		appendInstr(encodeU(rvIsaPkg::opAuipc, 26, 'h12345));
		appendInstr(encodeS(26, 10, 80));
		haltPos = prog.size();
		appendInstr(encodeJ(0, 0));
	endtask

	task automatic buildExpectedStores();
		logic [31:0] aluVals [8];
		aluVals = '{32'h0000_0902, 32'h0000_1353, 32'hFFFF_EDD0, 32'hFFFF_FB74,
			32'h00FF_FFFB, 32'hFF00_048F, 32'h0000_0001, 32'h0000_0000};
		for (int i = 0; i < 8; i++)
			expectStore(32'h80 + 32'(4 * i), aluVals[i]);
		for (int b = 0; b < 6; b++)
			expectStore(32'hA0 + 32'(4 * b), 32'd5);
		expectStore(32'hB8, dmem[5] + 32'h55);
		expectStore(32'hBC, 32'h0 - dmem[11]);
		expectStore(32'hC0, resetPc + 32'(4 * jalPos + 4));
		expectStore(32'hC4, resetPc + 32'(4 * jalrPos + 4));
		expectStore(32'hC8, resetPc + 32'(4 * auipcPos));
		expectStore(32'hCC, 32'hABCD_E000);
		expectStore(32'hD0, resetPc + 32'(4 * auipc2Pos) + 32'h1234_5000);
	endtask

	initial begin
		int          cycle;
		int          haltHits;
		int          storeIdx;
		int          sinceRelease;
		int          timeoutLimit;
		logic [31:0] haltPc;
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		readData = '0;
		cycle = 0;
		haltHits = 0;
		storeIdx = 0;
		void'($urandom(59838));
		for (int i = 0; i < dmemWords; i++)
			dmem[i] = $urandom();
		buildProgram();
		buildExpectedStores();
		for (int i = 0; i < imemWords; i++)
			imem[i] = '0;
		for (int i = 0; i < prog.size(); i++)
			imem[i] = prog[i];
		haltPc = resetPc + 32'(4 * haltPos);
		timeoutLimit = 3 * prog.size() + resetCycles + 50;

		// everything is sampled and driven mid-cycle, away from the rising edge
		while (haltHits < 3) begin
			@(negedge clk);
			cycle++;
			if (cycle > timeoutLimit)
				abortRun($sformatf("timeout: no final loop reached after %0d cycles", cycle));
			if (rst) begin
				assert (pc == resetPc && !memWrite)
					else abortRun($sformatf("FAILED at %0t: pc %h memWrite %b during reset",
						$time, pc, memWrite));
			end else begin
				sinceRelease = cycle - resetCycles;
				if (sinceRelease <= firstTakenPos + 2) begin
					assert (pc == resetPc + 32'(4 * sinceRelease) && (sinceRelease > 1 || !memWrite))
						else abortRun($sformatf("FAILED at %0t: pc %h, expected %h",
							$time, pc, resetPc + 32'(4 * sinceRelease)));
				end
				if (memWrite) begin
					assert (storeIdx < expAddr.size())
						else abortRun("the core made a store after all expected stores were seen");
					assert (dataAddr == expAddr[storeIdx] && writeData == expData[storeIdx])
						else abortRun($sformatf("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
							$time, storeIdx, writeData, dataAddr, expData[storeIdx], expAddr[storeIdx]));
					dmem[dataAddr[7:2]] = writeData;
					storeIdx++;
				end
				if (pc == haltPc)
					haltHits++;
			end
			if (cycle == resetCycles)
				rst = 1'b0;
			instr = imem[pc[8:2]];
			readData = dmem[dataAddr[7:2]];
		end

		if (storeIdx == expAddr.size()) begin
			$display("TEST OK");
			$finish;
		end else begin
			abortRun($sformatf("stores are missing: only %0d of %0d were seen",
				storeIdx, expAddr.size()));
		end
	end

endmodule

`default_nettype wire

// File: src.f
verilog/rvIsaPkg.sv
verilog/pipeCtrlPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/hazardUnit.sv
verilog/memWriteback.sv
verilog/riscvCore.sv
verif/riscvCoreTb.sv

// File: run.sh
#!/bin/sh
# build the core and its testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f src.f --top-module riscvCoreTb \
	-Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "TEST OK" "$logFile"; then
	exit 0
fi
echo "pass line not found in $logFile"
exit 1
